// File: Bender.yml
package:
  name: conv_pe

sources:
  - logic/conv_pkg.sv
  - logic/window_if.sv
  - logic/sum_if.sv
  - logic/window_scanner.sv
  - logic/kernel_mac_bank.sv
  - logic/requantizer.sv
  - logic/conv_pe_top.sv
  - target: test
    files:
      - testbench/tb_conv_pe.sv

// File: logic/conv_pe_top.sv
`timescale 1ns/100ps

module conv_pe_top (
    input  logic            clk,
    input  logic            arst_n,

    // one whole row per strobe
    input  logic            row_valid,
    input  conv_pkg::row_t  row_data,

    // one weight tap per strobe
    input  logic            wt_valid,
    input  conv_pkg::wsel_t wt_sel,
    input  conv_pkg::pix_t  wt_data,

    output logic            out_valid,
    output conv_pkg::col_t  out_col,
    output conv_pkg::chan_t out_data
);

    window_if u_win ();
    sum_if    u_sum ();

    // decode stage
    window_scanner u_window_scanner (
        .clk       (clk),
        .arst_n    (arst_n),
        .row_valid (row_valid),
        .row_data  (row_data),
        .win       (u_win.src)
    );

    // execute stage, holds the weights
    kernel_mac_bank u_kernel_mac_bank (
        .clk      (clk),
        .arst_n   (arst_n),
        .wt_valid (wt_valid),
        .wt_sel   (wt_sel),
        .wt_data  (wt_data),
        .win      (u_win.dst),
        .sums     (u_sum.src)
    );

    // result stage
    requantizer u_requantizer (
        .clk       (clk),
        .arst_n    (arst_n),
        .sums      (u_sum.dst),
        .out_valid (out_valid),
        .out_col   (out_col),
        .out_data  (out_data)
    );

endmodule

// File: logic/conv_pkg.sv
package conv_pkg;

    // pixel and weight width, two's complement
    localparam int PIX_W       = 9;
    localparam int ROW_LEN     = 32;
    localparam int K           = 3;
    localparam int NUM_KERNELS = 3;
    localparam int NUM_COLS    = ROW_LEN - K + 1;
    localparam int NUM_WTS     = NUM_KERNELS * K * K;

    // min cycles between row strobes
    localparam int ROW_GAP     = 32;

    // 18-bit product plus 4 growth bits for 9 terms
    localparam int ACC_W       = 22;
    localparam int ACC_SHIFT   = 4;

    // saturation bounds of the output pixel
    localparam int PIX_MAX     = 2 ** (PIX_W - 1) - 1;
    localparam int PIX_MIN     = -(2 ** (PIX_W - 1));

    typedef logic signed [PIX_W-1:0]         pix_t;

    // pixel 0 sits in the top bits
    typedef logic [ROW_LEN*PIX_W-1:0]        row_t;
    typedef logic [K*PIX_W-1:0]              tap3_t;

    typedef logic signed [ACC_W-1:0]         acc_t;
    typedef logic [$clog2(NUM_COLS)-1:0]     col_t;

    // kernel * 9 + row * 3 + column
    typedef logic [$clog2(NUM_WTS)-1:0]      wsel_t;

    // channel 0 in the low bits
    typedef logic [NUM_KERNELS*PIX_W-1:0]    chan_t;

    typedef enum logic [1:0] {
        FILL0,
        FILL1,
        IDLE,
        SCAN
    } scan_state_t;

endpackage

// File: logic/kernel_mac_bank.sv
`timescale 1ns/100ps

module kernel_mac_bank (
    input  logic            clk,
    input  logic            arst_n,
    input  logic            wt_valid,
    input  conv_pkg::wsel_t wt_sel,
    input  conv_pkg::pix_t  wt_data,
    window_if.dst           win,
    sum_if.src              sums
);

    conv_pkg::pix_t                        weights [conv_pkg::NUM_WTS];
    conv_pkg::pix_t                        win_pix [conv_pkg::K * conv_pkg::K];
    logic signed [2*conv_pkg::PIX_W-1:0]   prod_q  [conv_pkg::NUM_KERNELS][conv_pkg::K * conv_pkg::K];
    logic                                  prod_valid;
    conv_pkg::col_t                        prod_col;
    conv_pkg::acc_t                        sum_d   [conv_pkg::NUM_KERNELS];

    // pixel c of a window row, 0 is leftmost
    function automatic conv_pkg::pix_t pix_of(conv_pkg::tap3_t t, int c);
        return t[(conv_pkg::K - 1 - c) * conv_pkg::PIX_W +: conv_pkg::PIX_W];
    endfunction

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < conv_pkg::NUM_WTS; i++) begin
                weights[i] <= '0;
            end
        end else if (wt_valid && (int'(wt_sel) < conv_pkg::NUM_WTS)) begin
            weights[wt_sel] <= wt_data;
        end
    end

    // tap index is row * 3 + column
    always_comb begin
        for (int c = 0; c < conv_pkg::K; c++) begin
            win_pix[c]                   = pix_of(win.win_top, c);
            win_pix[conv_pkg::K + c]     = pix_of(win.win_mid, c);
            win_pix[2 * conv_pkg::K + c] = pix_of(win.win_bot, c);
        end
    end

    always_ff @(posedge clk) begin
        if (win.win_valid) begin
            prod_col <= win.win_col;
            for (int k = 0; k < conv_pkg::NUM_KERNELS; k++) begin
                for (int t = 0; t < conv_pkg::K * conv_pkg::K; t++) begin
                    prod_q[k][t] <= win_pix[t] * weights[k * conv_pkg::K * conv_pkg::K + t];
                end
            end
        end
    end

    // adder tree over the registered products
    always_comb begin
        for (int k = 0; k < conv_pkg::NUM_KERNELS; k++) begin
            sum_d[k] = '0;
            for (int t = 0; t < conv_pkg::K * conv_pkg::K; t++) begin
                sum_d[k] = sum_d[k] + prod_q[k][t];
            end
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            prod_valid     <= 1'b0;
            sums.sum_valid <= 1'b0;
        end else begin
            prod_valid     <= win.win_valid;
            sums.sum_valid <= prod_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (prod_valid) begin
            sums.sum_col <= prod_col;
            sums.sum0    <= sum_d[0];
            sums.sum1    <= sum_d[1];
            sums.sum2    <= sum_d[2];
        end
    end

endmodule

// File: logic/requantizer.sv
`timescale 1ns/100ps

module requantizer (
    input  logic            clk,
    input  logic            arst_n,
    sum_if.dst              sums,
    output logic            out_valid,
    output conv_pkg::col_t  out_col,
    output conv_pkg::chan_t out_data
);

    // floor shift, then clamp to the pixel range
    function automatic conv_pkg::pix_t requant(conv_pkg::acc_t sum);
        conv_pkg::acc_t shifted;
        shifted = sum >>> conv_pkg::ACC_SHIFT;
        if (shifted > conv_pkg::acc_t'(conv_pkg::PIX_MAX)) begin
            return conv_pkg::pix_t'(conv_pkg::PIX_MAX);
        end
        if (shifted < conv_pkg::acc_t'(conv_pkg::PIX_MIN)) begin
            return conv_pkg::pix_t'(conv_pkg::PIX_MIN);
        end
        return conv_pkg::pix_t'(shifted);
    endfunction

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            out_valid <= 1'b0;
        end else begin
            out_valid <= sums.sum_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (sums.sum_valid) begin
            out_col  <= sums.sum_col;
            out_data <= {requant(sums.sum2), requant(sums.sum1), requant(sums.sum0)};
        end
    end

endmodule

// File: logic/sum_if.sv
`timescale 1ns/100ps

// raw channel sums, before shift and clamp
interface sum_if;

    logic           sum_valid;
    conv_pkg::col_t sum_col;
    conv_pkg::acc_t sum0;
    conv_pkg::acc_t sum1;
    conv_pkg::acc_t sum2;

    modport src (
        output sum_valid, sum_col,
        output sum0, sum1, sum2
    );

    modport dst (
        input sum_valid, sum_col,
        input sum0, sum1, sum2
    );

endinterface

// File: logic/window_if.sv
`timescale 1ns/100ps

// one 3x3 window per strobe, top row is the oldest
interface window_if;

    logic            win_valid;
    conv_pkg::col_t  win_col;
    conv_pkg::tap3_t win_top;
    conv_pkg::tap3_t win_mid;
    conv_pkg::tap3_t win_bot;

    modport src (
        output win_valid, win_col,
        output win_top, win_mid, win_bot
    );

    modport dst (
        input win_valid, win_col,
        input win_top, win_mid, win_bot
    );

endinterface

// File: logic/window_scanner.sv
`timescale 1ns/100ps

module window_scanner (
    input  logic           clk,
    input  logic           arst_n,
    input  logic           row_valid,
    input  conv_pkg::row_t row_data,
    window_if.src          win
);

    conv_pkg::row_t        row_top;
    conv_pkg::row_t        row_mid;
    conv_pkg::row_t        row_bot;
    conv_pkg::scan_state_t state;
    conv_pkg::col_t        col_cnt;
    logic                  row_accept;
    logic                  last_col;

    // three adjacent pixels starting at column c
    function automatic conv_pkg::tap3_t tap_at(conv_pkg::row_t r, conv_pkg::col_t c);
        int base;
        base = (conv_pkg::ROW_LEN - conv_pkg::K - int'(c)) * conv_pkg::PIX_W;
        return r[base +: conv_pkg::K * conv_pkg::PIX_W];
    endfunction

    // rows arriving mid-scan are dropped
    assign row_accept = row_valid && (state != conv_pkg::SCAN);
    assign last_col   = (col_cnt == conv_pkg::col_t'(conv_pkg::NUM_COLS - 1));

    // row shift, oldest falls off the top
    always_ff @(posedge clk) begin
        if (row_accept) begin
            row_top <= row_mid;
            row_mid <= row_bot;
            row_bot <= row_data;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state   <= conv_pkg::FILL0;
            col_cnt <= '0;
        end else begin
            case (state)
                conv_pkg::FILL0: begin
                    if (row_accept) begin
                        state <= conv_pkg::FILL1;
                    end
                end
                conv_pkg::FILL1: begin
                    if (row_accept) begin
                        state <= conv_pkg::IDLE;
                    end
                end
                conv_pkg::IDLE: begin
                    if (row_accept) begin
                        state   <= conv_pkg::SCAN;
                        col_cnt <= '0;
                    end
                end
                conv_pkg::SCAN: begin
                    col_cnt <= col_cnt + 1'b1;
                    if (last_col) begin
                        state   <= conv_pkg::IDLE;
                        col_cnt <= '0;
                    end
                end
                default: state <= conv_pkg::FILL0;
            endcase
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            win.win_valid <= 1'b0;
        end else begin
            win.win_valid <= (state == conv_pkg::SCAN);
        end
    end

    // one window per scan cycle
    always_ff @(posedge clk) begin
        if (state == conv_pkg::SCAN) begin
            win.win_col <= col_cnt;
            win.win_top <= tap_at(row_top, col_cnt);
            win.win_mid <= tap_at(row_mid, col_cnt);
            win.win_bot <= tap_at(row_bot, col_cnt);
        end
    end

endmodule

// File: src.f
logic/conv_pkg.sv
logic/window_if.sv
logic/sum_if.sv
logic/window_scanner.sv
logic/kernel_mac_bank.sv
logic/requantizer.sv
logic/conv_pe_top.sv
testbench/tb_conv_pe.sv

// File: testbench/tb_conv_pe.sv
`timescale 1ns/100ps

module tb_conv_pe;

    // 4 x 27 weight writes plus 20 rows at up to 40 cycles each and margin
    localparam int TIMEOUT_CYCLES = 2000;
    localparam int NC = conv_pkg::NUM_COLS;

    logic            clk;
    logic            arst_n = 1'b0;
    logic            row_valid;
    logic            wt_valid;
    logic            out_valid;
    logic            scan_start;
    conv_pkg::row_t  row_data;
    conv_pkg::wsel_t wt_sel;
    conv_pkg::pix_t  wt_data;
    conv_pkg::col_t  out_col;
    conv_pkg::chan_t out_data;
    conv_pkg::chan_t last_out;
    conv_pkg::chan_t exp_data [NC];

    // reference model with row 0 as the oldest
    int ref_rows [3][conv_pkg::ROW_LEN];
    int ref_wts  [conv_pkg::NUM_WTS];
    int new_row  [conv_pkg::ROW_LEN];
    int rows_held = 0;
    int out_cnt = 0;
    int exp_cnt = 0;
    int err_cnt = 0;
    int pass_cnt = 0;
    int fail_cnt = 0;
    int cycles = 0;
    int seed = 94014;

    conv_pe_top u_conv_pe_top (
        .clk       (clk),
        .arst_n    (arst_n),
        .row_valid (row_valid),
        .row_data  (row_data),
        .wt_valid  (wt_valid),
        .wt_sel    (wt_sel),
        .wt_data   (wt_data),
        .out_valid (out_valid),
        .out_col   (out_col),
        .out_data  (out_data)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    initial begin
        while (cycles < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout: the run did not finish within %0d clock cycles", cycles);
        $display("TEST FAIL");
        $finish;
    end

    always @(negedge clk) begin
        if (arst_n && out_valid) begin
            out_cnt++;
            last_out = out_data;
        end
    end

    task automatic report_fail(string msg);
        $display("FAIL %0t: %s", $time, msg);
        err_cnt++;
    endtask

    // convolution, floor shift and clamp for one window column
    function automatic conv_pkg::chan_t calc_chan(int col);
        conv_pkg::chan_t res;
        int acc;
        for (int k = 0; k < 3; k++) begin
            acc = 0;
            for (int r = 0; r < 3; r++) begin
                for (int c = 0; c < 3; c++) begin
                    acc += ref_rows[r][col + c] * ref_wts[k * 9 + r * 3 + c];
                end
            end
            acc = acc >>> conv_pkg::ACC_SHIFT;
            acc = (acc > 255) ? 255 : ((acc < -256) ? -256 : acc);
            res[k * conv_pkg::PIX_W +: conv_pkg::PIX_W] = acc[8:0];
        end
        return res;
    endfunction

    function automatic int rand_pix();
        logic signed [8:0] v;
        v = $random(seed);
        return int'(v);
    endfunction

    a_reset: assert property (@(posedge clk) (!arst_n && cycles > 0) |-> !out_valid)
        else report_fail("out_valid high during reset");
    a_start: assert property (@(posedge clk) disable iff (!arst_n)
        $past(scan_start, 5) |-> $rose(out_valid))
        else report_fail("out_valid did not rise 5 edges after the row");
    a_rise_cause: assert property (@(posedge clk) disable iff (!arst_n)
        $rose(out_valid) |-> $past(scan_start, 5))
        else report_fail("out_valid rose without a scan starting row");
    a_col_first: assert property (@(posedge clk) disable iff (!arst_n)
        $rose(out_valid) |-> out_col == '0)
        else report_fail("scan does not start at column 0");
    a_col_step: assert property (@(posedge clk) disable iff (!arst_n)
        out_valid && $past(out_valid) |-> out_col == $past(out_col) + 1'b1)
        else report_fail("out_col did not step by one");
    a_run_end: assert property (@(posedge clk) disable iff (!arst_n)
        $fell(out_valid) |-> $past(out_col) == conv_pkg::col_t'(NC - 1))
        else report_fail("scan did not end at the last column");
    a_data: assert property (@(posedge clk) disable iff (!arst_n)
        out_valid |-> out_data == exp_data[out_col])
        else report_fail($sformatf("out_data %h at column %0d, expected %h",
                                   $sampled(out_data), $sampled(out_col),
                                   exp_data[$sampled(out_col)]));

    task automatic idle(int n);
        repeat (n) begin
            @(posedge clk);
            #1;
        end
    endtask

    task automatic do_reset();
        arst_n = 1'b0;
        rows_held = 0;
        for (int i = 0; i < conv_pkg::NUM_WTS; i++) begin
            ref_wts[i] = 0;
        end
        repeat (5) @(posedge clk);
        #1;
        arst_n = 1'b1;
    endtask

    task automatic load_weight(int sel, int val);
        wt_valid = 1'b1;
        wt_sel = conv_pkg::wsel_t'(sel);
        wt_data = conv_pkg::pix_t'(val);
        ref_wts[sel] = val;
        @(posedge clk);
        #1;
        wt_valid = 1'b0;
    endtask

    // a dropped row leaves the model untouched
    task automatic send_row(bit accepted);
        row_valid = 1'b1;
        for (int i = 0; i < conv_pkg::ROW_LEN; i++) begin
            row_data[(conv_pkg::ROW_LEN - 1 - i) * conv_pkg::PIX_W +: conv_pkg::PIX_W] =
                conv_pkg::pix_t'(new_row[i]);
        end
        if (accepted) begin
            ref_rows[0] = ref_rows[1];
            ref_rows[1] = ref_rows[2];
            ref_rows[2] = new_row;
            rows_held++;
        end
        scan_start = accepted && (rows_held >= 3);
        if (scan_start) begin
            exp_cnt += NC;
            for (int c = 0; c < NC; c++) begin
                exp_data[c] = calc_chan(c);
            end
        end
        @(posedge clk);
        #1;
        row_valid = 1'b0;
        scan_start = 1'b0;
    endtask

    task automatic wait_outputs();
        while (out_cnt < exp_cnt) begin
            @(posedge clk);
            #1;
        end
        idle(3);
    endtask

    task automatic feed_row();
        send_row(1'b1);
        if (rows_held >= 3) begin
            wait_outputs();
        end else begin
            idle(conv_pkg::ROW_GAP);
        end
    endtask

    task automatic random_row();
        for (int i = 0; i < conv_pkg::ROW_LEN; i++) begin
            new_row[i] = rand_pix();
        end
    endtask

    task automatic end_test(string name, int err_before);
        assert (out_cnt == exp_cnt)
        else report_fail($sformatf("%s: %0d outputs, expected %0d", name, out_cnt, exp_cnt));
        if (err_cnt == err_before) begin
            pass_cnt++;
            $display("test %s: passed", name);
        end else begin
            fail_cnt++;
            $display("test %s: failed", name);
        end
    endtask

    initial begin
        int err_before;
        row_valid = 1'b0;
        row_data = '0;
        wt_valid = 1'b0;
        wt_sel = '0;
        wt_data = '0;
        scan_start = 1'b0;

        // two fill rows give no output
        err_before = err_cnt;
        do_reset();
        repeat (2) begin
            random_row();
            feed_row();
        end
        end_test("reset", err_before);

        err_before = err_cnt;
        for (int i = 0; i < conv_pkg::NUM_WTS; i++) begin
            load_weight(i, (i % 9 == 4) ? 16 : 0);
        end
        random_row();
        feed_row();
        assert (last_out == {3{conv_pkg::pix_t'(ref_rows[1][NC])}})
        else report_fail("pass-through: last column is not the middle pixel");
        end_test("pass_through", err_before);

        err_before = err_cnt;
        do_reset();
        for (int i = 0; i < conv_pkg::NUM_WTS; i++) begin
            load_weight(i, rand_pix());
        end
        repeat (6) begin
            random_row();
            feed_row();
        end
        end_test("random", err_before);

        // uneven weights expose a stale row
        err_before = err_cnt;
        do_reset();
        for (int i = 0; i < conv_pkg::NUM_WTS; i++) begin
            load_weight(i, i - 13);
        end
        for (int n = 0; n < 4; n++) begin
            for (int i = 0; i < conv_pkg::ROW_LEN; i++) begin
                new_row[i] = (n * 61 + i * 7) % 200 - 100;
            end
            feed_row();
        end
        end_test("sliding", err_before);

        err_before = err_cnt;
        do_reset();
        for (int i = 0; i < conv_pkg::NUM_WTS; i++) begin
            load_weight(i, (i < 9) ? -256 : ((i < 18) ? 255 : rand_pix()));
        end
        for (int i = 0; i < conv_pkg::ROW_LEN; i++) begin
            new_row[i] = -256;
        end
        repeat (3) feed_row();
        assert (last_out[8:0] == 9'h0ff && last_out[17:9] == 9'h100)
        else report_fail("saturation: channel 0 or 1 not clamped to the pixel range");
        end_test("saturation", err_before);

        // second strobe lands mid-scan and must be dropped
        err_before = err_cnt;
        random_row();
        send_row(1'b1);
        idle(10);
        random_row();
        send_row(1'b0);
        wait_outputs();
        random_row();
        feed_row();
        end_test("latency", err_before);

        $display("tests passed %0d, failed %0d, check errors %0d", pass_cnt, fail_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule
